// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Integer word size
`define DATA_WIDTH 32

// Architectural register count
`define REG_COUNT 32

// Bits needed to name one register
`define REG_ADDR_WIDTH 5

`endif

// ==== cpuPkg.sv ====
`include "cpu_config.svh"

package cpuPkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [`DATA_WIDTH-1:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    // Major opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDI = 6'b001000;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR = 6'b100101;
    localparam logic [5:0] FN_SLT = 6'b101010;

    // ALU operation carried down the pipe
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Operand source select
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdMem = 2'b01,
        fwdWb = 2'b10
    } fwdSelT;

endpackage

// ==== exPipeIf.sv ====
// ID/EX pipeline register contents
interface exPipeIf;
    logic valid;
    cpuPkg::aluOpT aluOp;
    cpuPkg::regAddrT rs;
    cpuPkg::regAddrT rt;
    cpuPkg::regAddrT destReg;
    cpuPkg::wordT opA;
    cpuPkg::wordT opB;
    cpuPkg::wordT imm;
    logic useImm;
    logic writeEn;

    // Decode side owns the register
    modport decode (
        output valid, aluOp, rs, rt, destReg, opA, opB, imm, useImm, writeEn
    );

    // Execute side only reads it
    modport execute (
        input valid, aluOp, rs, rt, destReg, opA, opB, imm, useImm, writeEn
    );
endinterface

// ==== regFile.sv ====
`include "cpu_config.svh"

module regFile (
    input logic Clock,
    input logic rstN,
    input cpuPkg::regAddrT rdAddrA,
    input cpuPkg::regAddrT rdAddrB,
    output cpuPkg::wordT rdDataA,
    output cpuPkg::wordT rdDataB,
    input logic wrEn,
    input cpuPkg::regAddrT wrAddr,
    input cpuPkg::wordT wrData
);

    cpuPkg::wordT regs [`REG_COUNT];

    // Zero register first, then same-cycle write, then storage
    function automatic cpuPkg::wordT readPort(cpuPkg::regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn && addr == wrAddr) begin
            return wrData;
        end
        return regs[addr];
    endfunction

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            // Entry zero never changes
            regs[wrAddr] <= wrData;
        end
    end

    ////////////////////////////////////////
    // Read ports with write-through
    ////////////////////////////////////////

    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

    // Writers never target register zero
    assert property (@(posedge Clock) disable iff (!rstN)
        wrEn |-> wrAddr != '0);

endmodule

// ==== decodeStage.sv ====
`include "cpu_config.svh"

module decodeStage (
    input logic Clock,
    input logic rstN,
    input logic instrValid,
    input cpuPkg::instrT instr,
    output cpuPkg::regAddrT rdAddrA,
    output cpuPkg::regAddrT rdAddrB,
    input cpuPkg::wordT rdDataA,
    input cpuPkg::wordT rdDataB,
    exPipeIf.decode idEx
);

    logic [5:0] opcode;
    logic [5:0] funct;
    cpuPkg::regAddrT rs;
    cpuPkg::regAddrT rt;
    cpuPkg::regAddrT rd;
    logic supported;
    logic useImmNext;
    cpuPkg::aluOpT aluOpNext;
    cpuPkg::regAddrT destNext;
    cpuPkg::wordT immExt;

    ////////////////////////////////////////
    // Field split
    ////////////////////////////////////////

    assign opcode = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign funct = instr[5:0];

    // Sign extend the 16-bit immediate
    assign immExt = {{(`DATA_WIDTH - 16){instr[15]}}, instr[15:0]};

    // Source register reads happen during decode
    assign rdAddrA = rs;
    assign rdAddrB = rt;

    ////////////////////////////////////////
    // Opcode and function decode
    ////////////////////////////////////////

    always_comb begin
        supported = 1'b0;
        useImmNext = 1'b0;
        aluOpNext = cpuPkg::aluAdd;
        destNext = rd;
        if (opcode == cpuPkg::OP_ADDI) begin
            supported = 1'b1;
            useImmNext = 1'b1;
            // addi writes rt
            destNext = rt;
        end else if (opcode == cpuPkg::OP_RTYPE) begin
            supported = 1'b1;
            case (funct)
                cpuPkg::FN_ADD: aluOpNext = cpuPkg::aluAdd;
                cpuPkg::FN_SUB: aluOpNext = cpuPkg::aluSub;
                cpuPkg::FN_AND: aluOpNext = cpuPkg::aluAnd;
                cpuPkg::FN_OR: aluOpNext = cpuPkg::aluOr;
                cpuPkg::FN_SLT: aluOpNext = cpuPkg::aluSlt;
                default: supported = 1'b0;
            endcase
        end
    end

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    // Unsupported words become bubbles
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
            idEx.writeEn <= 1'b0;
        end else begin
            idEx.valid <= instrValid && supported;
            idEx.writeEn <= instrValid && supported && destNext != '0;
        end
    end

    // Payload follows every cycle
    always_ff @(posedge Clock) begin
        idEx.aluOp <= aluOpNext;
        idEx.rs <= rs;
        // addi has no rt source, so keep it out of forwarding
        idEx.rt <= useImmNext ? '0 : rt;
        idEx.destReg <= destNext;
        idEx.opA <= rdDataA;
        idEx.opB <= rdDataB;
        idEx.imm <= immExt;
        idEx.useImm <= useImmNext;
    end

endmodule

// ==== forwarder.sv ====
module forwarder (
    input logic exMemWriteEn,
    input cpuPkg::regAddrT exMemDest,
    input logic memWbWriteEn,
    input cpuPkg::regAddrT memWbDest,
    input cpuPkg::regAddrT rs,
    input cpuPkg::regAddrT rt,
    output cpuPkg::fwdSelT fwdSelA,
    output cpuPkg::fwdSelT fwdSelB
);

    ////////////////////////////////////////
    // Select rule for one source
    ////////////////////////////////////////

    function automatic cpuPkg::fwdSelT pickSource(cpuPkg::regAddrT src);
        // Register zero is constant, never forward it
        if (src == '0) begin
            return cpuPkg::fwdNone;
        end
        // Younger result in EX/MEM first
        if (exMemWriteEn && src == exMemDest) begin
            return cpuPkg::fwdMem;
        end
        // Older result still in MEM/WB
        if (memWbWriteEn && src == memWbDest) begin
            return cpuPkg::fwdWb;
        end
        return cpuPkg::fwdNone;
    endfunction

    always_comb begin
        fwdSelA = pickSource(rs);
        fwdSelB = pickSource(rt);
    end

endmodule

// ==== executeStage.sv ====
module executeStage (
    input logic Clock,
    input logic rstN,
    exPipeIf.execute idEx,
    output logic wrEn,
    output cpuPkg::regAddrT wrAddr,
    output cpuPkg::wordT wrData
);

    cpuPkg::fwdSelT fwdSelA;
    cpuPkg::fwdSelT fwdSelB;
    cpuPkg::wordT aluA;
    cpuPkg::wordT aluB;
    cpuPkg::wordT fwdB;
    cpuPkg::wordT aluResult;

    // EX/MEM stage
    logic exMemValid;
    logic exMemWriteEn;
    cpuPkg::regAddrT exMemDest;
    cpuPkg::wordT exMemResult;

    // MEM/WB stage
    logic memWbValid;
    logic memWbWriteEn;
    cpuPkg::regAddrT memWbDest;
    cpuPkg::wordT memWbResult;

    forwarder fwd (
        .exMemWriteEn(exMemValid && exMemWriteEn),
        .exMemDest(exMemDest),
        .memWbWriteEn(memWbValid && memWbWriteEn),
        .memWbDest(memWbDest),
        .rs(idEx.rs),
        .rt(idEx.rt),
        .fwdSelA(fwdSelA),
        .fwdSelB(fwdSelB)
    );

    ////////////////////////////////////////
    // Operand muxes and ALU
    ////////////////////////////////////////

    function automatic cpuPkg::wordT muxOperand(cpuPkg::fwdSelT sel,
                                                cpuPkg::wordT regVal,
                                                cpuPkg::wordT memVal,
                                                cpuPkg::wordT wbVal);
        case (sel)
            cpuPkg::fwdMem: return memVal;
            cpuPkg::fwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        aluA = muxOperand(fwdSelA, idEx.opA, exMemResult, memWbResult);
        fwdB = muxOperand(fwdSelB, idEx.opB, exMemResult, memWbResult);
        // Immediate replaces operand B for addi
        aluB = idEx.useImm ? idEx.imm : fwdB;
        case (idEx.aluOp)
            cpuPkg::aluSub: aluResult = aluA - aluB;
            cpuPkg::aluAnd: aluResult = aluA & aluB;
            cpuPkg::aluOr: aluResult = aluA | aluB;
            // Signed compare
            cpuPkg::aluSlt: aluResult = ($signed(aluA) < $signed(aluB)) ? 1 : 0;
            default: aluResult = aluA + aluB;
        endcase
    end

    ////////////////////////////////////////
    // EX/MEM and MEM/WB registers
    ////////////////////////////////////////

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            exMemValid <= 1'b0;
            exMemWriteEn <= 1'b0;
            memWbValid <= 1'b0;
            memWbWriteEn <= 1'b0;
        end else begin
            exMemValid <= idEx.valid;
            exMemWriteEn <= idEx.valid && idEx.writeEn;
            memWbValid <= exMemValid;
            memWbWriteEn <= exMemWriteEn;
        end
    end

    always_ff @(posedge Clock) begin
        exMemDest <= idEx.destReg;
        exMemResult <= aluResult;
        memWbDest <= exMemDest;
        memWbResult <= exMemResult;
    end

    // Write-back port straight from MEM/WB
    assign wrEn = memWbValid && memWbWriteEn;
    assign wrAddr = memWbDest;
    assign wrData = memWbResult;

    // Write-back never targets register zero
    assert property (@(posedge Clock) disable iff (!rstN)
        wrEn |-> wrAddr != '0);

endmodule

// ==== pipeCore.sv ====
module pipeCore (
    input logic Clock,
    input logic rstN,
    input logic instrValid,
    input cpuPkg::instrT instr,
    output logic wbValid,
    output cpuPkg::regAddrT wbReg,
    output cpuPkg::wordT wbData
);

    ////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////

    cpuPkg::regAddrT rdAddrA;
    cpuPkg::regAddrT rdAddrB;
    cpuPkg::wordT rdDataA;
    cpuPkg::wordT rdDataB;

    // ID/EX bundle
    exPipeIf idEx ();

    decodeStage decode (
        .Clock(Clock),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .idEx(idEx.decode)
    );

    // Write port shares the wb outputs
    regFile regs (
        .Clock(Clock),
        .rstN(rstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn(wbValid),
        .wrAddr(wbReg),
        .wrData(wbData)
    );

    executeStage execute (
        .Clock(Clock),
        .rstN(rstN),
        .idEx(idEx.execute),
        .wrEn(wbValid),
        .wrAddr(wbReg),
        .wrData(wbData)
    );

endmodule

// ==== tbPipeCore.sv ====
module tbPipeCore;
    timeunit 1ns;
    timeprecision 1ps;

    // One stimulus row
    typedef struct {
        cpuPkg::instrT word;
        logic wbFlag;
        cpuPkg::regAddrT regNum;
        cpuPkg::wordT value;
        logic tight;
    } rowT;

    // Write-back slot the pipe owes us
    typedef struct {
        int due;
        logic wbFlag;
        cpuPkg::regAddrT regNum;
        cpuPkg::wordT value;
    } expectT;

    logic Clock;
    logic rstN;
    logic instrValid;
    cpuPkg::instrT instr;
    logic wbValid;
    cpuPkg::regAddrT wbReg;
    cpuPkg::wordT wbData;

    rowT rows[$];
    expectT expQ[$];
    int edgeCount = 0;
    int limit = 0;
    int errors = 0;
    int checks = 0;

    pipeCore UUT (
        .Clock(Clock),
        .rstN(rstN),
        .instrValid(instrValid),
        .instr(instr),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    ////////////////////////////////////////
    // Clock and edge count
    ////////////////////////////////////////

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        edgeCount <= edgeCount + 1;
    end

    // Parse rows, skipping comment and blank lines
    task automatic readStimulus();
        int fd;
        int count;
        string line;
        logic [31:0] fWord;
        logic [31:0] fFlag;
        logic [31:0] fReg;
        logic [31:0] fValue;
        logic [31:0] fTight;
        rowT row;
        fd = $fopen("pipe_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open pipe_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            count = $sscanf(line, "%h %h %h %h %h", fWord, fFlag, fReg, fValue, fTight);
            if (count == 5) begin
                row.word = fWord;
                row.wbFlag = fFlag[0];
                row.regNum = fReg[4:0];
                row.value = fValue;
                row.tight = fTight[0];
                rows.push_back(row);
            end
        end
        $fclose(fd);
    endtask

    // One input slot, then wait for the next drive point
    task automatic driveSlot(input logic valid, input cpuPkg::instrT word);
        instrValid = valid;
        instr = word;
        @(posedge Clock);
        #5;
    endtask

    task automatic checkWriteBack(input expectT e);
        checks++;
        if (e.wbFlag) begin
            assert (wbValid === 1'b1) else begin
                errors++;
                $display("ERR t=%0t wbValid expected 1 actual %0b", $time, wbValid);
            end
            assert (wbReg === e.regNum) else begin
                errors++;
                $display("ERR t=%0t wbReg expected %0d actual %0d", $time, e.regNum, wbReg);
            end
            assert (wbData === e.value) else begin
                errors++;
                $display("ERR t=%0t wbData expected %h actual %h", $time, e.value, wbData);
            end
        end else begin
            assert (wbValid === 1'b0) else begin
                errors++;
                $display("ERR t=%0t wbValid expected 0 actual %0b", $time, wbValid);
            end
        end
    endtask

    ////////////////////////////////////////
    // Output monitor, mid-cycle
    ////////////////////////////////////////

    always @(negedge Clock) begin : monitor
        expectT slot;
        if (expQ.size() != 0 && expQ[0].due == edgeCount) begin
            slot = expQ.pop_front();
            checkWriteBack(slot);
        end else begin
            // Nothing due, covers reset too
            checks++;
            assert (wbValid === 1'b0) else begin
                errors++;
                $display("Stray write-back to register %0d at %0t", wbReg, $time);
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin : driver
        int bubbles;
        expectT e;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        void'($urandom(32'h8bce));
        readStimulus();
        if (rows.size() == 0) begin
            errors++;
            $display("No stimulus rows were read");
        end
        limit = rows.size() * 4 + 20;
        repeat (2) @(posedge Clock);
        #5;
        rstN = 1'b1;
        foreach (rows[i]) begin
            bubbles = rows[i].tight ? 0 : int'($urandom % 3);
            repeat (bubbles) driveSlot(1'b0, '0);
            // Sampled next edge, shows up in MEM/WB two edges later
            e.due = edgeCount + 3;
            e.wbFlag = rows[i].wbFlag;
            e.regNum = rows[i].regNum;
            e.value = rows[i].value;
            expQ.push_back(e);
            driveSlot(1'b1, rows[i].word);
        end
        instrValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge Clock);
        end
        // A few idle cycles to catch late writes
        repeat (3) @(posedge Clock);
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Cycle limit from the row count
    initial begin : watchdog
        wait (limit != 0);
        while (edgeCount < limit) begin
            @(posedge Clock);
        end
        $display("Run did not finish within %0d cycles", limit);
        $display("Done: %0d checks, %0d errors", checks, errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
cpuPkg.sv
exPipeIf.sv
regFile.sv
decodeStage.sv
forwarder.sv
executeStage.sv
pipeCore.sv
tbPipeCore.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=simPipeCore

verilator --binary --timing --assert \
    --top-module tbPipeCore \
    -f flist.f \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== pipe_stimulus.txt ====
// Columns: instruction word, expected write-back flag, register, value, tight
// All hex; tight 1 means no bubbles before the row
// Independent addi, register zero as source
20010005 1 01 00000005 0
2002FFFD 1 02 FFFFFFFD 0
20031234 1 03 00001234 0
20047FFF 1 04 00007FFF 0
// Back-to-back forwarding from EX/MEM into A, B and both
00232820 1 05 00001239 0
00A13020 1 06 0000123E 1
00463822 1 07 FFFFEDBF 1
00E74024 1 08 FFFFEDBF 1
21080001 1 08 FFFFEDC0 1
// Same register in EX/MEM and MEM/WB, younger wins
20090010 1 09 00000010 0
20090020 1 09 00000020 1
01295020 1 0A 00000040 1
// Distance two from MEM/WB
200B0100 1 0B 00000100 0
200C0003 1 0C 00000003 1
016C6825 1 0D 00000103 1
// Distance three through the register file bypass
200E0055 1 0E 00000055 0
200F0001 1 0F 00000001 1
20100002 1 10 00000002 1
01CF8820 1 11 00000056 1
// Destination zero and unsupported words write nothing
20200007 0 00 00000000 0
00019020 1 12 00000005 1
8C230004 0 00 00000000 0
00221827 0 00 00000000 0
// sub, and, or, slt
00619822 1 13 0000122F 0
0064A024 1 14 00001234 0
006CA825 1 15 00001237 0
0041B02A 1 16 00000001 0
0022B82A 1 17 00000000 0
00E2C02A 1 18 00000001 0
0018C82A 1 19 00000001 1
